/* source/vector_pkg.sv */
`default_nettype none

package vector_pkg;

    //////////////////////////////
    // widths

    localparam int elem_width = 8;
    localparam int addr_width = 16;

    //////////////////////////////
    // command and sequencer encodings

    typedef enum logic [7:0] {
        op_write     = 8'd1,
        op_read      = 8'd2,
        op_sum       = 8'd3,
        op_avg       = 8'd4,
        op_manhattan = 8'd5,
        op_sqdiff    = 8'd6,
        op_dot       = 8'd7
    } opcode_t;

    typedef enum logic [2:0] {
        idle,
        load,
        fetch,
        wait_alu,
        stream,
        wait_reduce,
        send
    } ctrl_state_t;

    //////////////////////////////
    // bundles between blocks

    // one shared address for both banks
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic                  a_we;
        logic                  b_we;
        logic [elem_width-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [elem_width-1:0] a;
        logic [elem_width-1:0] b;
    } elem_pair_t;

    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } stream_tag_t;

    // all fields are zero when strobe is low so loads can be ORed
    typedef struct packed {
        logic        strobe;
        logic [31:0] word;
        logic [2:0]  byte_count;
    } result_load_t;

endpackage

`default_nettype wire

/* source/vector_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_memory #(
    parameter int num_elements = 1024
) (
    input  logic                   clk,
    input  vector_pkg::mem_req_t   req,
    output vector_pkg::elem_pair_t pair
);
    import vector_pkg::*;

    localparam int index_width = (num_elements > 1) ? $clog2(num_elements) : 1;

    logic [elem_width-1:0] bank_a [num_elements];
    logic [elem_width-1:0] bank_b [num_elements];

    logic [index_width-1:0] index;

    assign index = req.addr[index_width-1:0];

    //////////////////////////////
    // write ports, one per bank

    always_ff @(posedge clk) begin
        if (req.a_we) begin
            bank_a[index] <= req.wdata;
        end
        if (req.b_we) begin
            bank_b[index] <= req.wdata;
        end
    end

    //////////////////////////////
    // shared read, one cycle latency

    always_ff @(posedge clk) begin
        pair.a <= bank_a[index];
        pair.b <= bank_b[index];
    end

endmodule

`default_nettype wire

/* source/vector_control.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_control #(
    parameter int num_elements = 1024
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              rx_valid,
    input  logic [7:0]                        rx_byte,
    input  vector_pkg::elem_pair_t            pair,
    input  logic [vector_pkg::elem_width:0]   alu_result,
    output vector_pkg::mem_req_t              req,
    output vector_pkg::stream_tag_t           tag,
    output vector_pkg::opcode_t               opcode,
    output vector_pkg::result_load_t          elem_load,
    input  logic                              send_done,
    output logic                              busy
);
    import vector_pkg::*;

    // last index of an element walk and of an interleaved byte walk
    localparam logic [addr_width:0] last_elem = (addr_width + 1)'(num_elements - 1);
    localparam logic [addr_width:0] last_byte = (addr_width + 1)'(2 * num_elements - 1);

    ctrl_state_t state;

    logic [addr_width:0]   count;
    logic [addr_width:0]   count_next;
    logic [addr_width:0]   last_count;
    logic [addr_width-1:0] next_addr;
    logic                  load_pending;
    logic                  is_reduction;
    logic                  valid_command;
    logic [elem_width-1:0] read_byte;

    assign count_next    = count + 1'b1;
    assign is_reduction  = (opcode == op_manhattan) || (opcode == op_sqdiff) ||
                           (opcode == op_dot);
    assign valid_command = (rx_byte >= op_write) && (rx_byte <= op_dot);
    assign busy          = (state != idle);

    // read walks bytes, sum and avg walk elements
    assign last_count = (opcode == op_read) ? last_byte : last_elem;
    assign next_addr  = (opcode == op_read) ? count_next[addr_width:1]
                                            : count_next[addr_width-1:0];

    //////////////////////////////
    // sequencer

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            count        <= '0;
            opcode       <= op_write;
            req          <= '0;
            tag          <= '0;
            load_pending <= 1'b0;
        end else begin
            req.a_we     <= 1'b0;
            req.b_we     <= 1'b0;
            tag          <= '0;
            load_pending <= (state == wait_alu);

            case (state)
                idle: begin
                    if (rx_valid && valid_command) begin
                        opcode   <= opcode_t'(rx_byte);
                        count    <= '0;
                        req.addr <= '0;
                        case (opcode_t'(rx_byte))
                            op_write: state <= load;
                            op_read, op_sum, op_avg: state <= fetch;
                            default: state <= stream;
                        endcase
                    end
                end

                load: begin
                    // even bytes go to bank a, odd bytes to bank b
                    if (rx_valid) begin
                        req.addr  <= count[addr_width:1];
                        req.a_we  <= ~count[0];
                        req.b_we  <= count[0];
                        req.wdata <= rx_byte;
                        count     <= count_next;
                        if (count == last_byte) begin
                            state <= idle;
                        end
                    end
                end

                fetch: begin
                    state <= wait_alu;
                end

                wait_alu: begin
                    state <= send;
                end

                stream: begin
                    // tag lands next cycle together with the memory data
                    tag.valid <= 1'b1;
                    tag.first <= (count == '0);
                    tag.last  <= (count == last_elem);
                    if (count == last_elem) begin
                        count <= '0;
                        state <= wait_reduce;
                    end else begin
                        count    <= count_next;
                        req.addr <= count_next[addr_width-1:0];
                    end
                end

                wait_reduce: begin
                    // drain the tag, term and accumulate stages
                    count <= count_next;
                    if (count == (addr_width + 1)'(1)) begin
                        state <= send;
                    end
                end

                send: begin
                    if (send_done) begin
                        if (is_reduction || (count == last_count)) begin
                            state <= idle;
                        end else begin
                            count    <= count_next;
                            req.addr <= next_addr;
                            state    <= fetch;
                        end
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // per-element load for the serializer

    // low bit of the byte counter picks the bank
    assign read_byte = count[0] ? pair.b : pair.a;

    always_comb begin
        elem_load = '0;
        if (load_pending) begin
            elem_load.strobe = 1'b1;
            case (opcode)
                op_read: begin
                    elem_load.word       = 32'(read_byte);
                    elem_load.byte_count = 3'd1;
                end
                op_sum: begin
                    elem_load.word       = 32'(alu_result);
                    elem_load.byte_count = 3'd2;
                end
                default: begin
                    elem_load.word       = 32'(alu_result);
                    elem_load.byte_count = 3'd1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/element_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module element_alu (
    input  logic                            clk,
    input  vector_pkg::elem_pair_t          pair,
    input  vector_pkg::opcode_t             opcode,
    output logic [vector_pkg::elem_width:0] result
);
    import vector_pkg::*;

    logic [elem_width:0] sum;
    logic [elem_width:0] avg;

    //////////////////////////////
    // combinational part

    // one extra bit keeps the carry
    assign sum = {1'b0, pair.a} + {1'b0, pair.b};

    // floor of the mean is the sum without its low bit
    assign avg = {1'b0, sum[elem_width:1]};

    //////////////////////////////
    // output register

    always_ff @(posedge clk) begin
        if (opcode == op_avg) begin
            result <= avg;
        end else begin
            result <= sum;
        end
    end

endmodule

`default_nettype wire

/* source/vector_reduction.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_reduction (
    input  logic                     clk,
    input  logic                     reset,
    input  vector_pkg::elem_pair_t   pair,
    input  vector_pkg::stream_tag_t  tag,
    input  vector_pkg::opcode_t      opcode,
    output vector_pkg::result_load_t load
);
    import vector_pkg::*;

    logic [elem_width-1:0]   abs_diff;
    logic [2*elem_width-1:0] sq_diff;
    logic [2*elem_width-1:0] product;

    logic [31:0] term;
    stream_tag_t term_tag;
    logic [31:0] acc;
    logic [31:0] total;

    //////////////////////////////
    // per-element term

    assign abs_diff = (pair.a > pair.b) ? (pair.a - pair.b) : (pair.b - pair.a);
    assign sq_diff  = (2*elem_width)'(abs_diff) * (2*elem_width)'(abs_diff);
    assign product  = (2*elem_width)'(pair.a) * (2*elem_width)'(pair.b);

    // registered so the multiplier has a full cycle
    always_ff @(posedge clk) begin
        case (opcode)
            op_manhattan: term <= 32'(abs_diff);
            op_sqdiff:    term <= 32'(sq_diff);
            default:      term <= 32'(product);
        endcase
    end

    //////////////////////////////
    // accumulate

    // first element restarts the sum
    assign total = term_tag.first ? term : (acc + term);

    always_ff @(posedge clk) begin
        if (term_tag.valid) begin
            acc <= total;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            term_tag <= '0;
            load     <= '0;
        end else begin
            term_tag <= tag;
            load     <= '0;
            if (term_tag.last) begin
                load.strobe     <= 1'b1;
                load.word       <= total;
                load.byte_count <= (opcode == op_manhattan) ? 3'd3 : 3'd4;
            end
        end
    end

endmodule

`default_nettype wire

/* source/result_serializer.sv */
`timescale 1ns/100ps
`default_nettype none

module result_serializer (
    input  logic                     clk,
    input  logic                     reset,
    input  vector_pkg::result_load_t load,
    input  logic                     tx_busy,
    output logic                     tx_start,
    output logic [7:0]               tx_byte,
    output logic                     send_done
);
    import vector_pkg::*;

    logic [31:0] shift_reg;
    logic [2:0]  remaining;
    logic        gap;
    logic        accept;

    // new word only when nothing is left to send
    assign accept = load.strobe && (remaining == 3'd0);

    // gap gives the transmitter a cycle to raise tx_busy
    assign tx_start = (remaining != 3'd0) && !tx_busy && !gap;
    assign tx_byte  = shift_reg[elem_width-1:0];

    //////////////////////////////
    // byte counter and pacing

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
            gap       <= 1'b0;
            send_done <= 1'b0;
        end else begin
            gap       <= tx_start;
            send_done <= tx_start && (remaining == 3'd1);
            if (tx_start) begin
                remaining <= remaining - 3'd1;
            end else if (accept) begin
                remaining <= load.byte_count;
            end
        end
    end

    // low byte goes out first
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= load.word;
        end else if (tx_start) begin
            shift_reg <= shift_reg >> elem_width;
        end
    end

endmodule

`default_nettype wire

/* source/vector_coprocessor.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_coprocessor #(
    parameter int num_elements = 1024
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_valid,
    input  logic [7:0] rx_byte,
    input  logic       tx_busy,
    output logic       tx_start,
    output logic [7:0] tx_byte,
    output logic       busy
);
    import vector_pkg::*;

    mem_req_t            req;
    elem_pair_t          pair;
    stream_tag_t         tag;
    opcode_t             opcode;
    logic [elem_width:0] alu_result;
    result_load_t        ctrl_load;
    result_load_t        red_load;
    result_load_t        tx_load;
    logic                send_done;

    // never both strobed in one cycle
    assign tx_load = ctrl_load | red_load;

    vector_memory #(.num_elements(num_elements)) i_memory (
        .clk  (clk),
        .req  (req),
        .pair (pair)
    );

    vector_control #(.num_elements(num_elements)) i_control (
        .clk        (clk),
        .reset      (reset),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .pair       (pair),
        .alu_result (alu_result),
        .req        (req),
        .tag        (tag),
        .opcode     (opcode),
        .elem_load  (ctrl_load),
        .send_done  (send_done),
        .busy       (busy)
    );

    element_alu i_alu (
        .clk    (clk),
        .pair   (pair),
        .opcode (opcode),
        .result (alu_result)
    );

    vector_reduction i_reduction (
        .clk    (clk),
        .reset  (reset),
        .pair   (pair),
        .tag    (tag),
        .opcode (opcode),
        .load   (red_load)
    );

    result_serializer i_serializer (
        .clk       (clk),
        .reset     (reset),
        .load      (tx_load),
        .tx_busy   (tx_busy),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .send_done (send_done)
    );

endmodule

`default_nettype wire

/* verification/vector_coprocessor_props.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_coprocessor_props (
    input logic clk,
    input logic reset,
    input logic tx_busy,
    input logic tx_start,
    input logic busy,
    input logic a_we,
    input logic b_we
);

    //////////////////////////////
    // transmit handshake

    // start only toward a free transmitter
    tx_start_when_free: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy)
        else $error("tx_start while tx_busy is high");

    tx_start_single_cycle: assert property (@(posedge clk) disable iff (reset)
        tx_start |=> !tx_start)
        else $error("tx_start high in two consecutive cycles");

    //////////////////////////////
    // reset values

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!busy && !tx_start && !a_we && !b_we))
        else $error("busy, tx_start or a write enable high after reset");

endmodule

bind vector_coprocessor vector_coprocessor_props i_props (
    .clk      (clk),
    .reset    (reset),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .busy     (busy),
    .a_we     (req.a_we),
    .b_we     (req.b_we)
);

`default_nettype wire

/* verification/vector_coprocessor_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_coprocessor_tb;
    import vector_pkg::*;

    localparam int num_elements = 8;
    localparam int wait_limit = 5000;

    logic       clk;
    logic       reset;
    logic       rx_valid;
    logic [7:0] rx_byte;
    logic       tx_busy;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       busy;

    integer     seed = 32'h455aeb1a;
    int         stall_left;
    int         stall_max;
    logic [7:0] vec_a [num_elements];
    logic [7:0] vec_b [num_elements];
    logic [7:0] received [$];
    logic [7:0] expected [$];

    vector_coprocessor #(.num_elements(num_elements)) i_dut (
        .clk      (clk),
        .reset    (reset),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .tx_busy  (tx_busy),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // collect every transmitted byte
    always @(posedge clk) begin
        if (tx_start) begin
            received.push_back(tx_byte);
        end
    end

    //////////////////////////////
    // failure reporting

    task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input int exp_value, input int act_value);
        assert (act_value == exp_value) else begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, what, exp_value, act_value);
            stop_on_error();
        end
    endtask

    //////////////////////////////
    // stimulus

    // one cycle, tx_busy redrawn at the falling edge in stretches
    task automatic tick();
        @(negedge clk);
        if (stall_left > 0) begin
            stall_left--;
        end else if (tx_busy) begin
            tx_busy    = 1'b0;
            stall_left = $unsigned($random(seed)) % 4;
        end else begin
            tx_busy    = 1'b1;
            stall_left = $unsigned($random(seed)) % stall_max;
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        rx_valid = 1'b1;
        rx_byte  = value;
        tick();
        rx_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            tick();
            cycles++;
            if (cycles > wait_limit) begin
                $display("timeout: busy stayed high after %0d cycles", wait_limit);
                stop_on_error();
            end
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < num_elements; i++) begin
            vec_a[i] = 8'($random(seed));
            vec_b[i] = 8'($random(seed));
        end
    endtask

    task automatic fill_const(input logic [7:0] a, input logic [7:0] b);
        for (int i = 0; i < num_elements; i++) begin
            vec_a[i] = a;
            vec_b[i] = b;
        end
    endtask

    // interleaved a0, b0, a1, b1
    task automatic write_vectors();
        send_byte(op_write);
        for (int i = 0; i < num_elements; i++) begin
            send_byte(vec_a[i]);
            send_byte(vec_b[i]);
        end
        wait_idle();
    endtask

    //////////////////////////////
    // reference model

    // least significant byte first
    task automatic push_word(input logic [31:0] value, input int count);
        for (int k = 0; k < count; k++) begin
            expected.push_back(value[8*k +: 8]);
        end
    endtask

    task automatic build_expected(input opcode_t op);
        logic [31:0] total;
        int          diff;
        expected.delete();
        total = '0;
        for (int i = 0; i < num_elements; i++) begin
            diff = int'(vec_a[i]) - int'(vec_b[i]);
            case (op)
                op_read: begin
                    expected.push_back(vec_a[i]);
                    expected.push_back(vec_b[i]);
                end
                op_sum:       push_word(int'(vec_a[i]) + int'(vec_b[i]), 2);
                op_avg:       expected.push_back(8'((int'(vec_a[i]) + int'(vec_b[i])) / 2));
                op_manhattan: total += (diff < 0) ? -diff : diff;
                op_sqdiff:    total += diff * diff;
                default:      total += int'(vec_a[i]) * int'(vec_b[i]);
            endcase
        end
        if (op == op_manhattan) begin
            push_word(total, 3);
        end else if (op == op_sqdiff || op == op_dot) begin
            push_word(total, 4);
        end
    endtask

    //////////////////////////////
    // checks

    // optional stray command while the operation runs
    task automatic run_command(input opcode_t op, input bit send_stray,
                               input logic [7:0] stray);
        build_expected(op);
        received.delete();
        send_byte(op);
        if (send_stray) begin
            send_byte(stray);
        end
        wait_idle();
        check_value($sformatf("byte count for opcode %0d", op), expected.size(),
                    received.size());
        foreach (expected[i]) begin
            check_value($sformatf("opcode %0d byte %0d", op, i), int'(expected[i]),
                        int'(received[i]));
        end
    endtask

    task automatic check_all_ops();
        run_command(op_read, 1'b0, 8'h00);
        run_command(op_sum, 1'b0, 8'h00);
        run_command(op_avg, 1'b0, 8'h00);
        run_command(op_manhattan, 1'b0, 8'h00);
        run_command(op_sqdiff, 1'b0, 8'h00);
        run_command(op_dot, 1'b0, 8'h00);
    endtask

    // fixed window, nothing may happen in it
    task automatic check_ignored(input logic [7:0] op);
        received.delete();
        send_byte(op);
        repeat (12) begin
            check_value("busy after unknown opcode", 0, int'(busy));
            tick();
        end
        check_value("bytes after unknown opcode", 0, received.size());
    endtask

    //////////////////////////////
    // test sequence

    initial begin
        reset      = 1'b1;
        rx_valid   = 1'b0;
        rx_byte    = 8'h00;
        tx_busy    = 1'b0;
        stall_left = 0;
        stall_max  = 2;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        tick();

        fill_random();
        write_vectors();
        check_all_ops();

        // corner values for the widest results
        fill_const(8'hff, 8'hff);
        write_vectors();
        check_all_ops();
        fill_const(8'hff, 8'h00);
        write_vectors();
        check_all_ops();
        fill_const(8'h00, 8'hff);
        write_vectors();
        check_all_ops();

        // long transmitter stalls
        stall_max = 40;
        fill_random();
        write_vectors();
        check_all_ops();
        stall_max = 2;

        check_ignored(8'h00);
        check_ignored(8'h09);

        fill_random();
        write_vectors();
        run_command(op_dot, 1'b1, op_sum);
        run_command(op_manhattan, 1'b1, op_write);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/vector_pkg.sv
source/vector_memory.sv
source/vector_control.sv
source/element_alu.sv
source/vector_reduction.sv
source/result_serializer.sv
source/vector_coprocessor.sv
verification/vector_coprocessor_props.sv
verification/vector_coprocessor_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vector_coprocessor_tb
FILE_LIST ?= build.f
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard source/*.sv) $(wildcard verification/*.sv)
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(SIM_DIR) $(LOG)
